//--- Makefile
VERILATOR ?= verilator
TOP       ?= caterpillar_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)

SOURCES := $(wildcard source/*.sv source/*.svh verification/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Run from the project root so the test data path resolves
run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)

//--- list.f
+incdir+source
source/game_types_pkg.sv
source/io_types_pkg.sv
source/tick_timer.sv
source/button_debounce.sv
source/game_fsm.sv
source/tone_player.sv
source/segment_display.sv
source/caterpillar_top.sv
verification/caterpillar_checker.sv
verification/caterpillar_tb.sv

//--- source/button_debounce.sv
`timescale 1ns/1ps
`include "caterpillar_defines.svh"

module button_debounce
    import game_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         tick,
    input  logic [3:0]   buttons,
    output input_event_t btn_event
);

    logic [3:0] btn_sync;           // Raw pins after one flop
    logic [3:0] level;              // Debounced state
    logic [3:0] stable_cnt [4];
    logic [3:0] rise_now;           // Press confirmed on this tick
    logic [1:0] first_btn;

    always_comb begin
        first_btn = 2'd0;
        for (int i = 0; i < 4; i++) begin
            rise_now[i] = tick && btn_sync[i] && !level[i]
                          && (stable_cnt[i] == 4'(`DEBOUNCE_TICKS - 1));
        end
        // Scan down so the lowest index wins
        for (int i = 3; i >= 0; i--) begin
            if (rise_now[i]) first_btn = 2'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            btn_sync  <= '0;
            level     <= '0;
            btn_event <= '0;
            for (int i = 0; i < 4; i++) stable_cnt[i] <= '0;
        end else begin
            btn_sync         <= buttons;
            btn_event.valid  <= |rise_now;
            btn_event.button <= first_btn;
            if (tick) begin
                for (int i = 0; i < 4; i++) begin
                    if (btn_sync[i] == level[i]) begin
                        stable_cnt[i] <= '0;        // Glitch or no change
                    end else if (stable_cnt[i] == 4'(`DEBOUNCE_TICKS - 1)) begin
                        level[i]      <= btn_sync[i];
                        stable_cnt[i] <= '0;
                    end else begin
                        stable_cnt[i] <= stable_cnt[i] + 4'd1;
                    end
                end
            end
        end
    end

endmodule

//--- source/caterpillar_defines.svh
`ifndef CATERPILLAR_DEFINES_SVH
`define CATERPILLAR_DEFINES_SVH

// Clock cycles per game tick, 200 Hz from a 50 kHz clock
`define TICK_DIV 250

// Ticks a pressed button must stay stable before it counts
`define DEBOUNCE_TICKS 4

// Length of one tone in ticks
`define TONE_TICKS 8

// Tone half period for button b is TONE_HALF_BASE + b ticks
`define TONE_HALF_BASE 2

`define ERROR_HALF 1        // Half period of the error buzz

`define LFSR_SEED 8'hA5     // Must be nonzero

`endif

//--- source/caterpillar_top.sv
`timescale 1ns/1ps

module caterpillar_top
    import game_types_pkg::*;
    import io_types_pkg::*;
(
    input  logic [7:0] ui_in,
    output logic [7:0] uo_out,
    input  logic [7:0] uio_in,     // Bidirectional pins run as outputs only
    output logic [7:0] uio_out,
    output logic [7:0] uio_oe,
    input  logic       ena,
    input  logic       clk,
    input  logic       rst_n
);

    logic         tick;
    input_event_t btn_event;
    logic         req;
    logic         ack;
    sound_req_t   snd_req;
    display_req_t disp;
    logic         sound;
    logic [3:0]   leds;
    logic [6:0]   segments;
    logic [1:0]   digit_sel;

    assign uo_out  = {1'b0, digit_sel, sound, leds};
    assign uio_out = {1'b0, segments};
    assign uio_oe  = 8'hff;

    tick_timer u_tick_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    button_debounce u_button_debounce (
        .clk       (clk),
        .rst_n     (rst_n),
        .tick      (tick),
        .buttons   (ui_in[3:0]),
        .btn_event (btn_event)
    );

    game_fsm u_game_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .tick      (tick),
        .btn_event (btn_event),
        .ack       (ack),
        .req       (req),
        .snd_req   (snd_req),
        .disp      (disp)
    );

    tone_player u_tone_player (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick    (tick),
        .req     (req),
        .snd_req (snd_req),
        .ack     (ack),
        .sound   (sound),
        .leds    (leds)
    );

    segment_display u_segment_display (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .disp       (disp),
        .seg_invert (ui_in[4]),
        .segments   (segments),
        .digit_sel  (digit_sel)
    );

endmodule

//--- source/game_fsm.sv
`timescale 1ns/1ps
`include "caterpillar_defines.svh"

module game_fsm
    import game_types_pkg::*;
    import io_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         tick,
    input  input_event_t btn_event,
    input  logic         ack,
    output logic         req,
    output sound_req_t   snd_req,
    output display_req_t disp
);

    game_state_e state;
    logic [7:0]  lfsr;          // Current step of the sequence
    logic [7:0]  lfsr_next;
    logic [4:0]  level;
    logic [4:0]  step;          // Index within the round
    logic        hs_idle;       // Both handshake wires low
    logic        press;

    // x^8 + x^6 + x^5 + x^4 + 1
    assign lfsr_next = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    assign hs_idle   = !req && !ack;
    assign press     = btn_event.valid && hs_idle;   // Presses during a tone are dropped

    assign disp.value     = level;
    assign disp.graphical = (state == OVER);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            req   <= 1'b0;
            lfsr  <= `LFSR_SEED;
            level <= '0;
            step  <= '0;
        end else begin
            if (req && ack) req <= 1'b0;    // Tone done, close handshake

            case (state)
                IDLE: begin
                    if (press) begin
                        level <= '0;
                        step  <= '0;
                        lfsr  <= `LFSR_SEED;
                        state <= SHOW;
                    end
                end

                SHOW: begin
                    // Start each shown tone on a tick so pulses stay apart
                    if (hs_idle && tick) begin
                        snd_req.mode   <= TONE;
                        snd_req.button <= lfsr[1:0];
                        req            <= 1'b1;
                        if (step == level) begin
                            step  <= '0;
                            lfsr  <= `LFSR_SEED;    // Rewind for the echo
                            state <= LISTEN;
                        end else begin
                            step <= step + 5'd1;
                            lfsr <= lfsr_next;
                        end
                    end
                end

                LISTEN: begin
                    if (press) begin
                        req            <= 1'b1;
                        snd_req.button <= btn_event.button;
                        if (btn_event.button == lfsr[1:0]) begin
                            snd_req.mode <= TONE;
                            if (step == level) begin
                                if (level != 5'd31) level <= level + 5'd1;
                                step  <= '0;
                                lfsr  <= `LFSR_SEED;
                                state <= SHOW;
                            end else begin
                                step <= step + 5'd1;
                                lfsr <= lfsr_next;
                            end
                        end else begin
                            snd_req.mode <= ERROR;
                            state        <= OVER;
                        end
                    end
                end

                OVER: begin
                    if (press) begin
                        level <= '0;
                        state <= IDLE;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- source/game_types_pkg.sv
package game_types_pkg;

    // Top level game phases
    typedef enum logic [1:0] {
        IDLE   = 2'd0,      // Waiting for a press to start
        SHOW   = 2'd1,      // Playing the sequence
        LISTEN = 2'd2,      // Player echoes the sequence
        OVER   = 2'd3       // Wrong press, dashes shown
    } game_state_e;

    // One debounced button press
    typedef struct packed {
        logic       valid;  // Single cycle pulse
        logic [1:0] button; // Lowest pressed index
    } input_event_t;

endpackage

//--- source/io_types_pkg.sv
package io_types_pkg;

    typedef enum logic {
        TONE  = 1'b0,       // Button tone, one LED
        ERROR = 1'b1        // Error buzz, all LEDs
    } sound_mode_e;

    // Payload of the tone handshake
    typedef struct packed {
        sound_mode_e mode;
        logic [1:0]  button;
    } sound_req_t;

    // What the seven segment display should show
    typedef struct packed {
        logic [4:0] value;      // Level, 0 to 31
        logic       graphical;  // Dashes instead of digits
    } display_req_t;

endpackage

//--- source/segment_display.sv
`timescale 1ns/1ps

module segment_display
    import io_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         tick,
    input  display_req_t disp,
    input  logic         seg_invert,
    output logic [6:0]   segments,
    output logic [1:0]   digit_sel
);

    display_req_t shown;
    logic [3:0]   tens;
    logic [3:0]   units;
    logic [3:0]   digit;
    logic [6:0]   pattern;      // Active high gfedcba

    always_comb begin
        if (shown.value >= 5'd30) tens = 4'd3;
        else if (shown.value >= 5'd20) tens = 4'd2;
        else if (shown.value >= 5'd10) tens = 4'd1;
        else tens = 4'd0;
        units = 4'(shown.value - 5'(tens * 4'd10));
        digit = digit_sel[0] ? units : tens;

        case (digit)
            4'd0: pattern = 7'b0111111;
            4'd1: pattern = 7'b0000110;
            4'd2: pattern = 7'b1011011;
            4'd3: pattern = 7'b1001111;
            4'd4: pattern = 7'b1100110;
            4'd5: pattern = 7'b1101101;
            4'd6: pattern = 7'b1111101;
            4'd7: pattern = 7'b0000111;
            4'd8: pattern = 7'b1111111;
            4'd9: pattern = 7'b1101111;
            default: pattern = 7'b0000000;
        endcase
        if (shown.graphical) pattern = 7'b1000000;  // Dash on both digits
    end

    assign segments = pattern ^ {7{seg_invert}};    // Common anode boards

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shown     <= '0;
            digit_sel <= 2'b01;                     // Units first
        end else begin
            shown <= disp;
            if (tick) digit_sel <= {digit_sel[0], digit_sel[1]};
        end
    end

endmodule

//--- source/tick_timer.sv
`timescale 1ns/1ps
`include "caterpillar_defines.svh"

module tick_timer (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    logic [15:0] div_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (div_cnt == 16'(`TICK_DIV - 1)) begin
                div_cnt <= '0;
                tick    <= 1'b1;    // One pulse per wrap
            end else begin
                div_cnt <= div_cnt + 16'd1;
            end
        end
    end

endmodule

//--- source/tone_player.sv
`timescale 1ns/1ps
`include "caterpillar_defines.svh"

module tone_player
    import io_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tick,
    input  logic       req,
    input  sound_req_t snd_req,
    output logic       ack,
    output logic       sound,
    output logic [3:0] leds
);

    typedef enum logic [1:0] {
        TP_IDLE,
        TP_PLAY,
        TP_DONE     // Waiting for req to fall
    } tp_state_e;

    tp_state_e  state;
    logic [3:0] tone_cnt;       // Ticks since tone start
    logic [2:0] half_cnt;       // Ticks in current half period
    logic [2:0] half_len;

    // snd_req stays stable for the whole handshake
    assign half_len = (snd_req.mode == ERROR) ? 3'(`ERROR_HALF)
                                              : 3'(`TONE_HALF_BASE) + {1'b0, snd_req.button};

    always_comb begin
        leds = 4'b0000;
        if (state == TP_PLAY) begin
            leds = (snd_req.mode == ERROR) ? 4'b1111 : 4'b0001 << snd_req.button;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= TP_IDLE;
            ack      <= 1'b0;
            sound    <= 1'b0;
            tone_cnt <= '0;
            half_cnt <= '0;
        end else begin
            case (state)
                TP_IDLE: begin
                    if (req) begin
                        tone_cnt <= '0;
                        half_cnt <= '0;
                        state    <= TP_PLAY;
                    end
                end
                TP_PLAY: begin
                    if (tick) begin
                        tone_cnt <= tone_cnt + 4'd1;
                        if (half_cnt == half_len - 3'd1) begin
                            half_cnt <= '0;
                            sound    <= !sound;
                        end else begin
                            half_cnt <= half_cnt + 3'd1;
                        end
                        if (tone_cnt == 4'(`TONE_TICKS - 1)) begin
                            sound <= 1'b0;              // Silence, LEDs go dark
                            ack   <= 1'b1;
                            state <= TP_DONE;
                        end
                    end
                end
                TP_DONE: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= TP_IDLE;
                    end
                end
                default: state <= TP_IDLE;
            endcase
        end
    end

endmodule

//--- verification/caterpillar_checker.sv
`timescale 1ns/1ps

module caterpillar_checker (
    input logic clk,
    input logic rst_n,
    input logic tick,
    input logic req,
    input logic ack,
    input logic pulse
);

    // req may only fall once the tone is acknowledged
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(req) |-> ack)
        else $error("req fell while ack was low");

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> req)
        else $error("ack rose without req");

    tick_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        tick |=> !tick)
        else $error("tick lasted more than one cycle");

    one_cycle_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        pulse |=> !pulse)
        else $error("a single cycle pulse lasted more than one cycle");

endmodule

bind game_fsm caterpillar_checker u_fsm_checker (
    .clk   (clk),
    .rst_n (rst_n),
    .tick  (tick),
    .req   (req),
    .ack   (ack),
    .pulse (btn_event.valid)
);

bind tone_player caterpillar_checker u_player_checker (
    .clk   (clk),
    .rst_n (rst_n),
    .tick  (tick),
    .req   (req),
    .ack   (ack),
    .pulse (ack && !req)    // ack drops right after req falls
);

//--- verification/caterpillar_tb.sv
`timescale 1ns/1ps
`include "caterpillar_defines.svh"

module tb_clock (
    output logic clk
);

    initial clk = 1'b0;
    always #10 clk = ~clk;      // 20 ns period

endmodule

module caterpillar_tb
    import io_types_pkg::*;
();

    typedef enum int {
        CMD_START,
        CMD_ROUND,
        CMD_WRONG,
        CMD_GLITCH,
        CMD_INVERT
    } cmd_e;

    logic       clk;
    logic       rst_n;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic       ena;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    cmd_e       cmd_q[$];
    int         arg_q[$];
    logic [3:0] pulse_q[$];     // LED pattern at the start of each pulse
    int         seq_q[$];       // Buttons of the last show
    int         exp_level   = 0;
    logic       invert      = 1'b0;
    bit         loaded      = 1'b0;

    longint     cycle       = 0;
    longint     last_edge   = 0;
    logic       edge_valid  = 1'b0;
    logic       prev_sound  = 1'b0;
    logic [3:0] prev_leds   = 4'b0000;

    tb_clock u_tb_clock (
        .clk (clk)
    );

    caterpillar_top u_caterpillar_top (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_leds(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("[FAIL] leds: got 0x%h expected 0x%h", got, exp));
    endtask

    task automatic check_sound(input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("[FAIL] sound: got 0x%h expected 0x%h", got, exp));
    endtask

    task automatic check_digit_sel(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("[FAIL] digit_sel: got 0x%h expected 0x%h", got, exp));
    endtask

    task automatic check_half_period(input int got, input int exp);
        if (got != exp)
            stop_with_failure($sformatf("[FAIL] sound half period: got 0x%h expected 0x%h",
                                        got, exp));
    endtask

    // Pins the tile ties to fixed values
    task automatic check_tie_offs();
        if (uio_oe !== 8'hff)
            stop_with_failure($sformatf("[FAIL] uio_oe: got 0x%h expected 0x%h",
                                        uio_oe, 8'hff));
        if (uo_out[7] !== 1'b0)
            stop_with_failure($sformatf("[FAIL] uo_out[7]: got 0x%h expected 0x%h",
                                        uo_out[7], 1'b0));
        if (uio_out[7] !== 1'b0)
            stop_with_failure($sformatf("[FAIL] uio_out[7]: got 0x%h expected 0x%h",
                                        uio_out[7], 1'b0));
    endtask

    // Standard active high gfedcba digits
    function automatic logic [6:0] seg_code(input logic [3:0] d);
        case (d)
            4'd0: return 7'h3f;
            4'd1: return 7'h06;
            4'd2: return 7'h5b;
            4'd3: return 7'h4f;
            4'd4: return 7'h66;
            4'd5: return 7'h6d;
            4'd6: return 7'h7d;
            4'd7: return 7'h07;
            4'd8: return 7'h7f;
            4'd9: return 7'h6f;
            default: return 7'h00;
        endcase
    endfunction

    function automatic int onehot_index(input logic [3:0] pat);
        for (int i = 0; i < 4; i++) begin
            if (pat[i]) return i;
        end
        return 0;
    endfunction

    function automatic int half_ticks(input logic [3:0] pat);
        if (pat == 4'b1111) return `ERROR_HALF;
        return `TONE_HALF_BASE + onehot_index(pat);
    endfunction

    function automatic display_req_t make_disp(input int value, input logic graphical);
        display_req_t d;
        d.value     = 5'(value);
        d.graphical = graphical;
        return d;
    endfunction

    task automatic check_display(input display_req_t exp);
        logic [1:0] sel;
        logic [3:0] digit;
        logic [6:0] pat;
        int         t;
        for (int k = 0; k < 2; k++) begin
            sel   = (k == 0) ? 2'b01 : 2'b10;      // Units, then tens
            digit = (k == 0) ? 4'(exp.value % 10) : 4'(exp.value / 10);
            pat   = exp.graphical ? 7'b1000000 : seg_code(digit);
            if (invert) pat = ~pat;
            t = 0;
            @(negedge clk);
            while (uo_out[6:5] != sel) begin
                @(negedge clk);
                t++;
                if (t > 2 * `TICK_DIV) stop_with_failure("digit_sel never selected the digit");
            end
            if (uio_out[6:0] !== pat)
                stop_with_failure($sformatf("[FAIL] segments (digit_sel %b): got 0x%h expected 0x%h",
                                            sel, uio_out[6:0], pat));
        end
    endtask

    task automatic wait_dark();
        int t;
        t = 0;
        @(negedge clk);
        while (uo_out[3:0] != 4'b0000) begin
            @(negedge clk);
            t++;
            if (t > 2 * `TONE_TICKS * `TICK_DIV) stop_with_failure("the LEDs stayed lit too long");
        end
    endtask

    task automatic wait_pulses(input int count);
        int t;
        t = 0;
        while (pulse_q.size() < count) begin
            @(posedge clk);
            t++;
            if (t > 4 * (`TONE_TICKS + `DEBOUNCE_TICKS) * `TICK_DIV)
                stop_with_failure("an expected LED pulse never appeared");
        end
    endtask

    // Hold past debounce, release, then let the release settle
    task automatic press_button(input int b);
        int hold;
        hold = `DEBOUNCE_TICKS + 2 + int'($urandom % 3);
        @(posedge clk);
        ui_in[3:0] <= 4'(1 << b);
        repeat (hold * `TICK_DIV) @(posedge clk);
        ui_in[3:0] <= 4'b0000;
        repeat ((`DEBOUNCE_TICKS + 2) * `TICK_DIV) @(posedge clk);
    endtask

    task automatic watch_show(input int count);
        logic [3:0] pat;
        seq_q.delete();
        for (int i = 0; i < count; i++) begin
            wait_pulses(1);
            pat = pulse_q.pop_front();
            check_leds(pat, 4'(1 << onehot_index(pat)));   // Must be one-hot
            seq_q.push_back(onehot_index(pat));
        end
        wait_dark();
        repeat (2 * `TICK_DIV) @(posedge clk);
        if (pulse_q.size() != 0) stop_with_failure("the show played more pulses than expected");
    endtask

    task automatic echo_button(input int b, input logic [3:0] exp_pat);
        logic [3:0] pat;
        wait_dark();
        press_button(b);
        wait_pulses(1);
        pat = pulse_q.pop_front();
        check_leds(pat, exp_pat);
    endtask

    task automatic load_commands();
        int            fd;
        int            arg;
        logic [63:0]   word;
        logic [2047:0] rest;
        fd = $fopen("verification/caterpillar_testdata.txt", "r");
        if (fd == 0) stop_with_failure("could not open the test data file");
        while ($fscanf(fd, "%s", word) == 1) begin
            arg = 0;
            if (word == 64'("#")) begin
                void'($fgets(rest, fd));
            end else begin
                if (word == 64'("ROUND") || word == 64'("INVERT")) void'($fscanf(fd, "%d", arg));
                if (word == 64'("START")) cmd_q.push_back(CMD_START);
                else if (word == 64'("ROUND")) cmd_q.push_back(CMD_ROUND);
                else if (word == 64'("WRONG")) cmd_q.push_back(CMD_WRONG);
                else if (word == 64'("GLITCH")) cmd_q.push_back(CMD_GLITCH);
                else if (word == 64'("INVERT")) cmd_q.push_back(CMD_INVERT);
                else stop_with_failure("unknown command in the test data file");
                arg_q.push_back(arg);
            end
        end
        $fclose(fd);
    endtask

    // Pulse recorder and sound edge spacing
    always @(negedge clk) begin
        cycle++;
        if (rst_n && uo_out[3:0] != 4'b0000) begin
            if (prev_leds == 4'b0000) pulse_q.push_back(uo_out[3:0]);
            if (uo_out[4] != prev_sound) begin
                if (edge_valid)
                    check_half_period(int'(cycle - last_edge),
                                      half_ticks(uo_out[3:0]) * `TICK_DIV);
                last_edge  = cycle;
                edge_valid = 1'b1;
            end
        end else begin
            edge_valid = 1'b0;
        end
        prev_leds  = uo_out[3:0];
        prev_sound = uo_out[4];
    end

    initial begin
        longint limit_ns;
        wait (loaded);
        limit_ns = longint'(cmd_q.size()) * 31 * (`TONE_TICKS + `DEBOUNCE_TICKS)
                   * `TICK_DIV * 20;
        #(limit_ns);
        stop_with_failure($sformatf("watchdog expired after %0d ns", limit_ns));
    end

    initial begin
        ui_in  = 8'h00;
        uio_in = 8'h00;
        ena    = 1'b1;
        rst_n  = 1'b0;
        void'($urandom(77267));
        load_commands();
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_leds(uo_out[3:0], 4'b0000);
        check_sound(uo_out[4], 1'b0);
        check_digit_sel(uo_out[6:5], 2'b01);
        check_tie_offs();
        check_display(make_disp(0, 1'b0));

        foreach (cmd_q[i]) begin
            case (cmd_q[i])
                CMD_START: begin
                    press_button(0);
                end
                CMD_ROUND: begin
                    watch_show(exp_level + 1);
                    foreach (seq_q[j]) echo_button(seq_q[j], 4'(1 << seq_q[j]));
                    exp_level = arg_q[i];
                    check_display(make_disp(exp_level, 1'b0));
                end
                CMD_WRONG: begin
                    watch_show(exp_level + 1);
                    echo_button((seq_q[0] + 1) % 4, 4'b1111);   // Error buzz
                    wait_dark();
                    check_display(make_disp(exp_level, 1'b1));
                    press_button(0);                            // Back to idle
                    exp_level = 0;
                    check_display(make_disp(0, 1'b0));
                    if (pulse_q.size() != 0) stop_with_failure("a press in game over played a tone");
                end
                CMD_GLITCH: begin
                    @(posedge clk);
                    ui_in[1] <= 1'b1;
                    repeat ((`DEBOUNCE_TICKS - 2) * `TICK_DIV) @(posedge clk);
                    ui_in[1] <= 1'b0;
                    repeat ((`TONE_TICKS + `DEBOUNCE_TICKS) * `TICK_DIV) @(posedge clk);
                    if (pulse_q.size() != 0) stop_with_failure("a short glitch produced an LED pulse");
                    check_display(make_disp(exp_level, 1'b0));
                end
                CMD_INVERT: begin
                    @(posedge clk);
                    ui_in[4] <= (arg_q[i] != 0);
                    invert = (arg_q[i] != 0);
                    @(posedge clk);
                    check_display(make_disp(exp_level, 1'b0));
                end
                default: stop_with_failure("unhandled command");
            endcase
        end

        repeat (2 * `TICK_DIV) @(posedge clk);
        check_tie_offs();
        if (pulse_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure("the run ended with stray LED pulses");
        end
    end

endmodule

//--- verification/caterpillar_testdata.txt
# columns: command, then an argument for ROUND (level after the round) and INVERT (0 or 1)
# commands: START, ROUND <level>, WRONG, GLITCH, INVERT <0|1>
GLITCH
START
ROUND 1
ROUND 2
INVERT 1
ROUND 3
INVERT 0
WRONG
GLITCH
START
ROUND 1
WRONG
